// File: Makefile
# Verilator build and run for the clock controller testbench

VERILATOR ?= verilator
TOP       ?= tb_clock_controller
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: clk_divider.sv
// Power-of-two counter divider with divided clocks and one-cycle pre-edge enables
`timescale 1ns/1ps

module clk_divider import clk_pkg::*; (
  input  logic     clk_in,
  input  logic     arst_n,
  output div_bus_t taps
);

  logic [MAX_DIV_LOG-1:0] cnt;
  logic [MAX_DIV_LOG-1:0] cnt_next;
  logic [NUM_TAPS-1:1]    en_d;
  logic [NUM_TAPS-1:1]    en_q;

  // Counting down makes every tap rise on the step from zero to all ones
  assign cnt_next = cnt - 1'b1;

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else begin
      cnt <= cnt_next;
    end
  end

  // Tap k rises after a cycle whose counter bits below k are all zero
  always_comb begin
    for (int k = 1; k < NUM_TAPS; k++) begin
      en_d[k] = ((cnt_next & MAX_DIV_LOG'((1 << k) - 1)) == '0);
    end
  end

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      en_q <= '0;
    end else begin
      en_q <= en_d;
    end
  end

  // Tap 0 is the input clock, its enable is always on
  assign taps.clk = {cnt, clk_in};
  assign taps.en  = {en_q, 1'b1};

  // Each enable is followed by a rising edge of its tap
  for (genvar k = 1; k < NUM_TAPS; k++) begin : g_en_chk
    a_en_pre_edge: assert property (
      @(posedge clk_in) disable iff (!arst_n)
      en_q[k] |=> $rose(cnt[k-1])
    );
  end

endmodule

// File: clk_gate.sv
// Latch-based integrated clock gate cell
`timescale 1ns/1ps

module clk_gate (
  input  logic clk_in,
  input  logic en,
  output logic gclk
);

  logic en_lat;

  // ------------------------------------------------------------------
  // Enable latch, open while the clock is low
  // ------------------------------------------------------------------

  // Enable settles during the low phase and holds through the high phase
  always_latch begin
    if (!clk_in) begin
      en_lat <= en;
    end
  end

  // High phase passes only whole
  assign gclk = clk_in & en_lat;

endmodule

// File: clk_pkg.sv
// Divider constants, select code type and control and clock bundles
package clk_pkg;

  // ------------------------------------------------------------------
  // Divider geometry
  // ------------------------------------------------------------------

  // Taps are divide by 1, 2, 4, 8, 16 and 32
  localparam int NUM_TAPS    = 6;
  localparam int MAX_DIV_LOG = NUM_TAPS - 1;

  // Select code, tap index is min(code, MAX_DIV_LOG)
  typedef logic [2:0] clk_sel_t;

  // ------------------------------------------------------------------
  // Bundles
  // ------------------------------------------------------------------

  // Divider outputs, one clock and one pre-edge enable per tap
  typedef struct packed {
    logic [NUM_TAPS-1:0] clk;
    logic [NUM_TAPS-1:0] en;
  } div_bus_t;

  // Per-peripheral control levels
  typedef struct packed {
    logic     gate;   // high stops the clock
    clk_sel_t sel;
  } periph_ctrl_t;

  // Per-peripheral clock outputs
  typedef struct packed {
    logic fclk;
    logic gclk;
    logic gclk_en;
  } periph_clk_t;

endpackage

// File: clk_tap_selector.sv
// Divider tap selector that switches taps only at counter wrap
`timescale 1ns/1ps

module clk_tap_selector import clk_pkg::*; (
  input  logic     clk_in,
  input  logic     arst_n,
  input  div_bus_t taps,
  input  clk_sel_t sel,
  output logic     clk_out,
  output logic     en_out
);

  clk_sel_t sel_sat;
  clk_sel_t pending;
  clk_sel_t active;
  logic     wrap;

  // Codes 6 and 7 fall back to the slowest tap
  assign sel_sat = (sel > clk_sel_t'(MAX_DIV_LOG)) ? clk_sel_t'(MAX_DIV_LOG) : sel;

  always_ff @(posedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      pending <= '0;
    end else begin
      pending <= sel_sat;
    end
  end

  // ------------------------------------------------------------------
  // Active code update
  // ------------------------------------------------------------------

  // Top enable marks the wrap cycle, where every tap is low
  assign wrap = taps.en[MAX_DIV_LOG];

  // Falling edge inside the wrap cycle, input clock low as well
  always_ff @(negedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      active <= '0;
    end else if (wrap) begin
      active <= pending;
    end
  end

  assign clk_out = taps.clk[active];
  assign en_out  = taps.en[active];

  // A tap change is only seen while all divided clocks are low
  a_switch_at_wrap: assert property (
    @(posedge clk_in) disable iff (!arst_n)
    $changed(active) |-> (taps.clk[NUM_TAPS-1:1] == '0)
  );

endmodule

// File: clock_controller.sv
// Top level with master switch, dividers, system clock select, block gates and peripheral channels
`timescale 1ns/1ps

module clock_controller import clk_pkg::*; #(
  parameter int SYNC_STAGES = 2
) (
  input  logic         master_clk,
  input  logic         alt_master_clk,
  input  logic         arst_n,
  input  logic         master_sel,
  input  clk_sel_t     sys_sel,
  input  logic         cpu_gate,
  input  logic         dma_gate,
  input  periph_ctrl_t timer_ctrl,
  input  periph_ctrl_t uart_ctrl,
  input  periph_ctrl_t dma_pclk_ctrl,
  output logic         sys_fclk,
  output logic         cpu_gclk,
  output logic         dma_gclk,
  output periph_clk_t  timer_clk,
  output periph_clk_t  uart_clk,
  output periph_clk_t  dma_pclk
);

  logic     root_clk;
  logic     sys_clk_raw;
  div_bus_t master_taps;
  div_bus_t sys_taps;

  // ------------------------------------------------------------------
  // Master clock and system clock
  // ------------------------------------------------------------------

  master_clk_switch #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_master_sw (
    .clk0    (master_clk),
    .clk1    (alt_master_clk),
    .arst_n  (arst_n),
    .sel     (master_sel),
    .clk_out (root_clk)
  );

  clk_divider u_master_div (
    .clk_in (root_clk),
    .arst_n (arst_n),
    .taps   (master_taps)
  );

  // Enable output is not needed on the system path
  clk_tap_selector u_sys_sel (
    .clk_in  (root_clk),
    .arst_n  (arst_n),
    .taps    (master_taps),
    .sel     (sys_sel),
    .clk_out (sys_clk_raw),
    .en_out  ()
  );

  // Same cell on every branch keeps the insertion delays matched
  clk_gate u_sys_gate (
    .clk_in (sys_clk_raw),
    .en     (1'b1),
    .gclk   (sys_fclk)
  );

  clk_gate u_cpu_gate (
    .clk_in (sys_clk_raw),
    .en     (~cpu_gate),
    .gclk   (cpu_gclk)
  );

  clk_gate u_dma_gate (
    .clk_in (sys_clk_raw),
    .en     (~dma_gate),
    .gclk   (dma_gclk)
  );

  // ------------------------------------------------------------------
  // Peripheral clocks, derived from the system clock
  // ------------------------------------------------------------------

  clk_divider u_sys_div (
    .clk_in (sys_fclk),
    .arst_n (arst_n),
    .taps   (sys_taps)
  );

  periph_clk_channel u_timer_ch (
    .clk_in (sys_fclk),
    .arst_n (arst_n),
    .taps   (sys_taps),
    .ctrl   (timer_ctrl),
    .clks   (timer_clk)
  );

  periph_clk_channel u_uart_ch (
    .clk_in (sys_fclk),
    .arst_n (arst_n),
    .taps   (sys_taps),
    .ctrl   (uart_ctrl),
    .clks   (uart_clk)
  );

  // DMA peripheral side runs off the enable, its gclk stays low
  periph_clk_channel #(
    .HAS_GCLK (1'b0)
  ) u_dma_pclk_ch (
    .clk_in (sys_fclk),
    .arst_n (arst_n),
    .taps   (sys_taps),
    .ctrl   (dma_pclk_ctrl),
    .clks   (dma_pclk)
  );

endmodule

// File: flist.f
clk_pkg.sv
master_clk_switch.sv
clk_divider.sv
clk_tap_selector.sv
clk_gate.sv
periph_clk_channel.sv
clock_controller.sv
tb_clk_gen.sv
tb_clock_controller.sv

// File: master_clk_switch.sv
// Glitch-free 2:1 master clock switch with cross-coupled enable synchronizers
`timescale 1ns/1ps

module master_clk_switch #(
  parameter int SYNC_STAGES = 2
) (
  input  logic clk0,
  input  logic clk1,
  input  logic arst_n,
  input  logic sel,
  output logic clk_out
);

  logic [SYNC_STAGES-1:0] sync0;
  logic [SYNC_STAGES-1:0] sync1;
  logic                   req0;
  logic                   req1;
  logic                   en0;
  logic                   en1;

  // A side may request only while the other chain is fully drained
  assign req0 = ~sel & ~(|sync1);
  assign req1 =  sel & ~(|sync0);

  // ------------------------------------------------------------------
  // Enable chains, clocked on the falling edge of their own clock
  // ------------------------------------------------------------------

  // clk0 side comes out of reset enabled
  always_ff @(negedge clk0 or negedge arst_n) begin
    if (!arst_n) begin
      sync0 <= '1;
    end else begin
      sync0 <= (sync0 << 1) | SYNC_STAGES'(req0);
    end
  end

  always_ff @(negedge clk1 or negedge arst_n) begin
    if (!arst_n) begin
      sync1 <= '0;
    end else begin
      sync1 <= (sync1 << 1) | SYNC_STAGES'(req1);
    end
  end

  assign en0 = sync0[SYNC_STAGES-1];
  assign en1 = sync1[SYNC_STAGES-1];

  // Enables only move while their clock is low, so no runt pulse
  assign clk_out = (clk0 & en0) | (clk1 & en1);

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  // The two sides never drive the output together
  a_excl_clk0: assert property (
    @(posedge clk0) disable iff (!arst_n) !(en0 && en1)
  );

  a_excl_clk1: assert property (
    @(posedge clk1) disable iff (!arst_n) !(en0 && en1)
  );

endmodule

// File: periph_clk_channel.sv
// Peripheral clock channel with free-running clock, gated clock and gated enable
`timescale 1ns/1ps

module periph_clk_channel import clk_pkg::*; #(
  parameter bit HAS_GCLK = 1'b1
) (
  input  logic         clk_in,
  input  logic         arst_n,
  input  div_bus_t     taps,
  input  periph_ctrl_t ctrl,
  output periph_clk_t  clks
);

  logic fclk;
  logic sel_en;
  logic gclk;
  logic en_q;

  // Selected tap and its pre-edge enable
  clk_tap_selector u_tap_sel (
    .clk_in  (clk_in),
    .arst_n  (arst_n),
    .taps    (taps),
    .sel     (ctrl.sel),
    .clk_out (fclk),
    .en_out  (sel_en)
  );

  // Gated clock only where the channel has one
  if (HAS_GCLK) begin : g_gclk
    clk_gate u_gate (
      .clk_in (fclk),
      .en     (~ctrl.gate),
      .gclk   (gclk)
    );
  end else begin : g_no_gclk
    assign gclk = 1'b0;
  end

  // ------------------------------------------------------------------
  // Gated enable
  // ------------------------------------------------------------------

  // Half-cycle shift centres the pulse on the system clock rising edge
  always_ff @(negedge clk_in or negedge arst_n) begin
    if (!arst_n) begin
      en_q <= 1'b0;
    end else begin
      en_q <= sel_en & ~ctrl.gate;
    end
  end

  assign clks.fclk    = fclk;
  assign clks.gclk    = gclk;
  assign clks.gclk_en = en_q & ~ctrl.gate;   // drops as soon as gate goes high

endmodule

// File: tb_clk_gen.sv
// Free-running testbench clock source
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD = 40.0
) (
  output logic clk
);

  // Starts low, first rising edge after half a period
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2.0);
      clk = ~clk;
    end
  end

endmodule

// File: tb_clock_controller.sv
// Table-driven clock controller testbench with period, pulse and level checks
`timescale 1ns/1ps

module tb_clock_controller import clk_pkg::*; ();

  localparam int NUM_ROWS  = 12;
  localparam int NUM_FIXED = 8;
  localparam int P_SYS     = 0;
  localparam int P_CPU     = 1;
  localparam int P_DMA     = 2;

  // Channel order in ctrl is timer, uart, dma_pclk
  typedef struct packed {
    logic               master_sel;
    clk_sel_t           sys_sel;
    logic               cpu_gate;
    logic               dma_gate;
    periph_ctrl_t [2:0] ctrl;
  } row_t;

  logic         master_clk;
  logic         alt_master_clk;
  logic         arst_n;
  logic         master_sel;
  clk_sel_t     sys_sel;
  logic         cpu_gate;
  logic         dma_gate;
  periph_ctrl_t timer_ctrl;
  periph_ctrl_t uart_ctrl;
  periph_ctrl_t dma_pclk_ctrl;
  logic         sys_fclk;
  logic         cpu_gclk;
  logic         dma_gclk;
  periph_clk_t  timer_clk;
  periph_clk_t  uart_clk;
  periph_clk_t  dma_pclk;

  row_t        rows [NUM_ROWS];
  realtime     exp_sys [NUM_ROWS];
  realtime     exp_per [NUM_ROWS][3];
  realtime     hi_time [12];
  logic [11:0] probes;
  logic [11:0] snap;
  realtime     rise_t = 0.0;
  logic        runt_seen = 1'b0;
  int          n_tests = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  string       ch_name [3] = '{"timer_clk", "uart_clk", "dma_pclk"};

  tb_clk_gen #(.PERIOD(40.0))  u_master_gen (.clk(master_clk));
  tb_clk_gen #(.PERIOD(100.0)) u_alt_gen    (.clk(alt_master_clk));

  clock_controller #(
    .SYNC_STAGES (2)
  ) i_dut (
    .master_clk     (master_clk),
    .alt_master_clk (alt_master_clk),
    .arst_n         (arst_n),
    .master_sel     (master_sel),
    .sys_sel        (sys_sel),
    .cpu_gate       (cpu_gate),
    .dma_gate       (dma_gate),
    .timer_ctrl     (timer_ctrl),
    .uart_ctrl      (uart_ctrl),
    .dma_pclk_ctrl  (dma_pclk_ctrl),
    .sys_fclk       (sys_fclk),
    .cpu_gclk       (cpu_gclk),
    .dma_gclk       (dma_gclk),
    .timer_clk      (timer_clk),
    .uart_clk       (uart_clk),
    .dma_pclk       (dma_pclk)
  );

  // Channel c has fclk at bit 5+3c, gclk below it, gclk_en below that
  assign probes = {dma_pclk, uart_clk, timer_clk, dma_gclk, cpu_gclk, sys_fclk};

  // High pulses shorter than half the faster source period are runts
  always @(posedge sys_fclk) begin
    rise_t = $realtime;
  end

  always @(negedge sys_fclk) begin
    if (arst_n && ($realtime - rise_t) < 19.99) begin
      runt_seen = 1'b1;
    end
  end

  // ------------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------------

  function automatic bit [31:0] lcg_next(input bit [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Divide ratio is two to the power min(code, 5)
  function automatic realtime ratio(input clk_sel_t code);
    return (code > 3'd5) ? 32.0 : real'(1 << code);
  endfunction

  function automatic row_t make_row(input logic ms, input clk_sel_t ss, input logic cg,
                                    input logic dg, input periph_ctrl_t t,
                                    input periph_ctrl_t u, input periph_ctrl_t d);
    row_t row;
    row.master_sel = ms;
    row.sys_sel    = ss;
    row.cpu_gate   = cg;
    row.dma_gate   = dg;
    row.ctrl[0]    = t;
    row.ctrl[1]    = u;
    row.ctrl[2]    = d;
    return row;
  endfunction

  task automatic build_table();
    bit [31:0] seed;
    int        r;
    int        c;
    seed = 32'hef64_7fb1;
    // Columns are master_sel, sys_sel, cpu_gate, dma_gate, then timer,
    // uart and dma_pclk controls as {gate, sel}
    rows[0] = make_row(1'b0, 3'd0, 1'b0, 1'b0, 4'h1, 4'h2, 4'h0);
    rows[1] = make_row(1'b0, 3'd1, 1'b1, 1'b0, 4'h9, 4'h0, 4'h4);
    rows[2] = make_row(1'b0, 3'd3, 1'b0, 1'b1, 4'h6, 4'h9, 4'hA);
    rows[3] = make_row(1'b0, 3'd6, 1'b0, 1'b0, 4'h0, 4'h7, 4'h3);
    rows[4] = make_row(1'b0, 3'd7, 1'b1, 1'b1, 4'h5, 4'hC, 4'h1);
    rows[5] = make_row(1'b1, 3'd0, 1'b0, 1'b0, 4'h2, 4'h3, 4'h8);
    rows[6] = make_row(1'b1, 3'd2, 1'b0, 1'b1, 4'h7, 4'h1, 4'h5);
    rows[7] = make_row(1'b0, 3'd5, 1'b0, 1'b0, 4'h3, 4'h4, 4'h0);
    for (r = NUM_FIXED; r < NUM_ROWS; r++) begin
      seed    = lcg_next(seed);
      rows[r] = make_row(seed[31], seed[30:28], seed[27], seed[26],
                         seed[25:22], seed[21:18], seed[17:14]);
    end
    for (r = 0; r < NUM_ROWS; r++) begin
      exp_sys[r] = (rows[r].master_sel ? 100.0 : 40.0) * ratio(rows[r].sys_sel);
      for (c = 0; c < 3; c++) begin
        exp_per[r][c] = exp_sys[r] * ratio(rows[r].ctrl[c].sel);
      end
    end
  endtask

  // ------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------

  task automatic check_period(input string name, input realtime want, input realtime got);
    n_checks++;
    if (got < want - 0.01 || got > want + 0.01) begin
      n_errors++;
      $display("FAIL %0t %s: expected %0.1f ns, got %0.1f ns", $realtime, name, want, got);
    end
  endtask

  task automatic check_level(input string name, input logic want, input logic got);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("FAIL %0t %s: expected %b, got %b", $realtime, name, want, got);
    end
  endtask

  task automatic check_clks(input string name, input periph_clk_t want, input periph_clk_t got);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("FAIL %0t %s fclk/gclk/gclk_en: expected %b, got %b",
               $realtime, name, want, got);
    end
  endtask

  task automatic report_timeout(input string what);
    n_checks++;
    n_errors++;
    $display("%0t timeout, %s", $realtime, what);
  endtask

  // ------------------------------------------------------------------
  // Edge polling, samples sit half a ns off every clock edge
  // ------------------------------------------------------------------

  task automatic wait_rises(input int idx, input int n, input realtime limit, output bit ok);
    realtime t0;
    logic    prev;
    int      i;
    ok = 1'b1;
    for (i = 0; i < n && ok; i++) begin
      t0 = $realtime;
      do begin
        prev = probes[idx];
        #1;
      end while (!(!prev && probes[idx]) && ($realtime - t0) < limit);
      ok = !prev && probes[idx];
    end
  endtask

  // Two rising-edge intervals, high times of every probe over the first
  task automatic measure(input int idx, input realtime limit, output realtime p1,
                         output realtime p2, output bit ok);
    realtime t_start;
    realtime t_edge [3];
    logic    prev;
    int      edges;
    int      i;
    t_start = $realtime;
    edges   = 0;
    p1      = 0.0;
    p2      = 0.0;
    for (i = 0; i < 12; i++) begin
      hi_time[i] = 0.0;
    end
    prev = probes[idx];
    while (edges < 3 && ($realtime - t_start) < limit) begin
      #1;
      if (!prev && probes[idx]) begin
        t_edge[edges] = $realtime;
        edges++;
        if (edges == 1) begin
          snap = probes;
        end
      end
      if (edges == 1) begin
        for (i = 0; i < 12; i++) begin
          if (probes[i] === 1'b1) begin
            hi_time[i] += 1.0;
          end
        end
      end
      prev = probes[idx];
    end
    ok = (edges == 3);
    if (ok) begin
      p1 = t_edge[1] - t_edge[0];
      p2 = t_edge[2] - t_edge[1];
    end
  endtask

  // ------------------------------------------------------------------
  // One table row
  // ------------------------------------------------------------------

  task automatic run_row(input int r);
    realtime     src;
    realtime     sys_p;
    realtime     per;
    realtime     deadline;
    realtime     p1;
    realtime     p2;
    bit          ok;
    bit          gated;
    int          c;
    int          f;
    periph_clk_t want;
    src      = rows[r].master_sel ? 100.0 : 40.0;
    sys_p    = exp_sys[r];
    deadline = $realtime + 200.0 * src;
    p1       = 0.0;
    p2       = 0.0;
    ok       = 1'b1;
    // Settled once two clean system periods are seen
    while (ok && (p1 != sys_p || p2 != sys_p)) begin
      if ($realtime >= deadline) begin
        ok = 1'b0;
      end else begin
        measure(P_SYS, deadline - $realtime, p1, p2, ok);
      end
    end
    if (!ok) begin
      report_timeout($sformatf("sys_fclk never settled to a %0.1f ns period", sys_p));
      return;
    end
    measure(P_SYS, 4.0 * sys_p, p1, p2, ok);
    if (!ok) begin
      report_timeout("sys_fclk stopped rising after it settled");
      return;
    end
    check_period("sys_fclk period", sys_p, p1);
    check_period("sys_fclk period", sys_p, p2);
    check_period("cpu_gclk high time", rows[r].cpu_gate ? 0.0 : sys_p / 2.0, hi_time[P_CPU]);
    check_period("dma_gclk high time", rows[r].dma_gate ? 0.0 : sys_p / 2.0, hi_time[P_DMA]);
    check_level("cpu_gclk", ~rows[r].cpu_gate, snap[P_CPU]);
    check_level("dma_gclk", ~rows[r].dma_gate, snap[P_DMA]);
    check_level("sys_fclk runt pulse", 1'b0, runt_seen);
    // Channel selects take effect at the next divider wrap
    wait_rises(P_SYS, 34, 2.0 * sys_p, ok);
    if (!ok) begin
      report_timeout("sys_fclk rising edge never came before the channel checks");
      return;
    end
    for (c = 0; c < 3; c++) begin
      f     = 5 + 3 * c;
      per   = exp_per[r][c];
      gated = rows[r].ctrl[c].gate;
      measure(f, 3.0 * per + 2.0 * sys_p, p1, p2, ok);
      if (!ok) begin
        report_timeout({"no rising edge on ", ch_name[c], ".fclk"});
      end else begin
        want.fclk    = 1'b1;
        want.gclk    = (c != 2) && !gated;
        want.gclk_en = !gated;
        check_period({ch_name[c], ".fclk period"}, per, p1);
        check_period({ch_name[c], ".fclk period"}, per, p2);
        check_period({ch_name[c], ".gclk high time"}, want.gclk ? per / 2.0 : 0.0,
                     hi_time[f - 1]);
        check_period({ch_name[c], ".gclk_en high time"}, gated ? 0.0 : sys_p,
                     hi_time[f - 2]);
        check_clks(ch_name[c], want, periph_clk_t'(snap[f -: 3]));
      end
    end
  endtask

  // ------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------

  initial begin
    int r;
    int errs_before;
    $timeformat(-9, 1, " ns", 10);
    arst_n        = 1'b0;
    master_sel    = 1'b0;
    sys_sel       = '0;
    cpu_gate      = 1'b0;
    dma_gate      = 1'b0;
    timer_ctrl    = '0;
    uart_ctrl     = '0;
    dma_pclk_ctrl = '0;
    build_table();

    // Outputs are checked in the low phase near the end of reset
    repeat (7) @(negedge master_clk);
    #0.5;
    check_clks("timer_clk in reset", '0, timer_clk);
    check_clks("uart_clk in reset", '0, uart_clk);
    check_clks("dma_pclk in reset", '0, dma_pclk);
    check_level("cpu_gclk in reset", 1'b0, cpu_gclk);
    @(negedge master_clk);
    arst_n = 1'b1;

    for (r = 0; r < NUM_ROWS; r++) begin
      errs_before = n_errors;
      @(negedge master_clk);
      master_sel    = rows[r].master_sel;
      sys_sel       = rows[r].sys_sel;
      cpu_gate      = rows[r].cpu_gate;
      dma_gate      = rows[r].dma_gate;
      timer_ctrl    = rows[r].ctrl[0];
      uart_ctrl     = rows[r].ctrl[1];
      dma_pclk_ctrl = rows[r].ctrl[2];
      runt_seen     = 1'b0;
      #0.5;
      run_row(r);
      n_tests++;
      $display("row %0d master_sel=%0d sys_sel=%0d: %0d errors", r, rows[r].master_sel,
               rows[r].sys_sel, n_errors - errs_before);
    end

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
